// File: debug_pkg.sv
package debug_pkg;

    localparam int DATA_W      = 32;
    localparam int NUM_REGS    = 32;
    localparam int IF_ID_W     = 32;
    localparam int ID_EX_W     = 129;
    localparam int EX_MEM_W    = 77;
    localparam int MEM_WB_W    = 71;
    localparam int IMEM_ADDR_W = 8;
    localparam int DMEM_ADDR_W = 6;

    localparam int BAUD_DIV   = 4;   // Simulation rate
    localparam int OVERSAMPLE = 16;

    // Dump lengths in bytes, latches padded up to whole bytes
    localparam int WORD_BYTES   = DATA_W / 8;
    localparam int REGS_BYTES   = NUM_REGS * DATA_W / 8;
    localparam int IF_ID_BYTES  = (IF_ID_W + 7) / 8;
    localparam int ID_EX_BYTES  = (ID_EX_W + 7) / 8;
    localparam int EX_MEM_BYTES = (EX_MEM_W + 7) / 8;
    localparam int MEM_WB_BYTES = (MEM_WB_W + 7) / 8;
    localparam int DUMP_BUF_W   = REGS_BYTES * 8;   // Widest field

    typedef enum logic [7:0] {
        CMD_REGS     = 8'h01,
        CMD_IF_ID    = 8'h02,
        CMD_ID_EX    = 8'h03,
        CMD_EX_MEM   = 8'h04,
        CMD_MEM_WB   = 8'h05,
        CMD_LOAD     = 8'h07,
        CMD_CONT     = 8'h08,
        CMD_STEPMODE = 8'h09,
        CMD_STEP     = 8'h0A,
        CMD_MEMREAD  = 8'h0B
    } cmd_e;

    // Order follows command codes 01 to 05
    typedef enum logic [2:0] {
        DUMP_REGS,
        DUMP_IF_ID,
        DUMP_ID_EX,
        DUMP_EX_MEM,
        DUMP_MEM_WB,
        DUMP_MEM
    } dump_sel_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_DUMP,
        ST_LOAD_COUNT,
        ST_LOAD_DATA,
        ST_MEM_ADDR,
        ST_STEP
    } ctrl_state_e;

    typedef struct packed {
        logic [NUM_REGS-1:0][DATA_W-1:0] regs;   // Register 0 in the low bits
        logic [IF_ID_W-1:0]              if_id;
        logic [ID_EX_W-1:0]              id_ex;
        logic [EX_MEM_W-1:0]             ex_mem;
        logic [MEM_WB_W-1:0]             mem_wb;
        logic [DATA_W-1:0]               dmem_word;
    } dbg_snapshot_t;

    typedef struct packed {
        logic                   valid;
        logic [IMEM_ADDR_W-1:0] addr;
        logic [DATA_W-1:0]      data;
    } imem_write_t;

endpackage

// File: baud_tick_gen.sv
module baud_tick_gen (
    input  logic i_clk,
    input  logic i_reset,
    output logic o_tick
);
    import debug_pkg::*;

    logic [$clog2(BAUD_DIV)-1:0] count;

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            count  <= '0;
            o_tick <= 1'b0;
        end else begin
            o_tick <= (count == $bits(count)'(BAUD_DIV - 1));
            if (count == $bits(count)'(BAUD_DIV - 1)) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

// File: uart_rx.sv
module uart_rx (
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_tick,
    input  logic       i_rx,
    output logic [7:0] o_data,
    output logic       o_valid
);
    import debug_pkg::*;

    logic                          rx_meta, rx_sync;
    logic                          busy;
    logic [3:0]                    bit_cnt;   // 0 start, 1..8 data, 9 stop
    logic [$clog2(OVERSAMPLE)-1:0] tick_cnt;
    logic [7:0]                    shreg;
    logic                          sample;

    // Start bit is sampled at half a bit, the rest one full bit later
    assign sample = i_tick && (tick_cnt == ((bit_cnt == 4'd0) ?
                    $bits(tick_cnt)'(OVERSAMPLE / 2 - 1) : $bits(tick_cnt)'(OVERSAMPLE - 1)));

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            rx_meta  <= 1'b1;
            rx_sync  <= 1'b1;
            busy     <= 1'b0;
            bit_cnt  <= '0;
            tick_cnt <= '0;
            o_valid  <= 1'b0;
        end else begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
            o_valid <= 1'b0;
            if (!busy) begin
                if (!rx_sync) begin   // Falling edge of start bit
                    busy     <= 1'b1;
                    bit_cnt  <= '0;
                    tick_cnt <= '0;
                end
            end else if (sample) begin
                tick_cnt <= '0;
                if (bit_cnt == 4'd0) begin
                    if (rx_sync) begin
                        busy <= 1'b0;   // Glitch, not a start bit
                    end else begin
                        bit_cnt <= 4'd1;
                    end
                end else if (bit_cnt == 4'd9) begin
                    busy    <= 1'b0;
                    o_valid <= rx_sync;   // Bad stop bit drops the frame
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else if (i_tick) begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (busy && sample && bit_cnt != 4'd0 && bit_cnt != 4'd9) begin
            shreg <= {rx_sync, shreg[7:1]};   // LSB arrives first
        end
        if (busy && sample && bit_cnt == 4'd9) begin
            o_data <= shreg;
        end
    end

    a_valid_single: assert property (@(posedge i_clk) disable iff (i_reset)
        o_valid |=> !o_valid);

endmodule

// File: uart_tx.sv
module uart_tx (
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_tick,
    input  logic       i_start,
    input  logic [7:0] i_data,
    output logic       o_tx,
    output logic       o_done
);
    import debug_pkg::*;

    logic                          busy;
    logic [9:0]                    shreg;   // Stop, data, start
    logic [3:0]                    bit_cnt;
    logic [$clog2(OVERSAMPLE)-1:0] tick_cnt;

    // Shift register fills with ones, so the line idles high
    assign o_tx = shreg[0];

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            busy     <= 1'b0;
            shreg    <= '1;
            bit_cnt  <= '0;
            tick_cnt <= '0;
            o_done   <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (!busy) begin
                if (i_start) begin
                    busy     <= 1'b1;
                    shreg    <= {1'b1, i_data, 1'b0};
                    bit_cnt  <= '0;
                    tick_cnt <= '0;
                end
            end else if (i_tick) begin
                if (tick_cnt == $bits(tick_cnt)'(OVERSAMPLE - 1)) begin
                    tick_cnt <= '0;
                    shreg    <= {1'b1, shreg[9:1]};
                    if (bit_cnt == 4'd9) begin
                        busy   <= 1'b0;
                        o_done <= 1'b1;   // End of stop bit
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end else begin
                    tick_cnt <= tick_cnt + 1'b1;
                end
            end
        end
    end

    a_no_start_busy: assert property (@(posedge i_clk) disable iff (i_reset)
        i_start |-> !busy);

endmodule

// File: debug_control.sv
module debug_control (
    input  logic                               i_clk,
    input  logic                               i_reset,
    input  logic [7:0]                         i_rx_data,
    input  logic                               i_rx_valid,
    input  logic                               i_dump_done,
    input  logic                               i_load_done,
    output logic                               o_dump_start,
    output debug_pkg::dump_sel_e               o_dump_sel,
    output logic                               o_load_begin,
    output logic [7:0]                         o_load_count,
    output logic                               o_load_byte_valid,
    output logic [debug_pkg::DMEM_ADDR_W-1:0]  o_dmem_addr,
    output logic                               o_run,
    output logic                               o_step,
    output logic                               o_busy
);
    import debug_pkg::*;

    ctrl_state_e state;
    logic        run_mode;   // 1 continuous, 0 single step
    logic        loading;

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state        <= ST_IDLE;
            run_mode     <= 1'b1;
            o_dump_start <= 1'b0;
            o_dump_sel   <= DUMP_REGS;
            o_dmem_addr  <= '0;
        end else begin
            o_dump_start <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (i_rx_valid) begin
                        case (cmd_e'(i_rx_data))
                            CMD_REGS, CMD_IF_ID, CMD_ID_EX, CMD_EX_MEM, CMD_MEM_WB: begin
                                // Codes 01..05 map onto selects 0..4
                                o_dump_sel   <= dump_sel_e'(i_rx_data[2:0] - 3'd1);
                                o_dump_start <= 1'b1;
                                state        <= ST_DUMP;
                            end
                            CMD_LOAD:     state <= ST_LOAD_COUNT;
                            CMD_CONT:     run_mode <= 1'b1;
                            CMD_STEPMODE: run_mode <= 1'b0;
                            CMD_STEP: begin
                                if (!run_mode) begin
                                    state <= ST_STEP;
                                end
                            end
                            CMD_MEMREAD:  state <= ST_MEM_ADDR;
                            default: ;    // Unknown byte
                        endcase
                    end
                end
                ST_DUMP: begin
                    if (i_dump_done) begin
                        state <= ST_IDLE;
                    end
                end
                ST_LOAD_COUNT: begin
                    if (i_rx_valid) begin
                        state <= (i_rx_data == 8'd0) ? ST_IDLE : ST_LOAD_DATA;
                    end
                end
                ST_LOAD_DATA: begin
                    if (i_load_done) begin
                        state <= ST_IDLE;
                    end
                end
                ST_MEM_ADDR: begin
                    if (i_rx_valid) begin
                        o_dmem_addr  <= i_rx_data[DMEM_ADDR_W-1:0];
                        o_dump_sel   <= DUMP_MEM;
                        o_dump_start <= 1'b1;
                        state        <= ST_DUMP;
                    end
                end
                ST_STEP: state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign loading           = (state == ST_LOAD_COUNT) || (state == ST_LOAD_DATA);
    assign o_load_begin      = (state == ST_LOAD_COUNT) && i_rx_valid && (i_rx_data != 8'd0);
    assign o_load_count      = i_rx_data;
    assign o_load_byte_valid = (state == ST_LOAD_DATA) && i_rx_valid;

    // Pipeline stops during a load, the saved mode comes back after
    assign o_run  = run_mode && !loading;
    assign o_step = (state == ST_STEP);
    assign o_busy = (state != ST_IDLE);

    a_step_in_step_mode: assert property (@(posedge i_clk) disable iff (i_reset)
        o_step |-> !run_mode);

endmodule

// File: dump_serializer.sv
module dump_serializer (
    input  logic                     i_clk,
    input  logic                     i_reset,
    input  logic                     i_start,
    input  debug_pkg::dump_sel_e     i_sel,
    input  debug_pkg::dbg_snapshot_t i_snapshot,
    input  logic                     i_tx_done,
    output logic                     o_tx_start,
    output logic [7:0]               o_tx_data,
    output logic                     o_done
);
    import debug_pkg::*;

    logic [DUMP_BUF_W-1:0] field_buf;
    logic [6:0]            idx;
    logic [6:0]            last_idx;
    logic                  active;

    // Copy taken at start so the dump is one consistent view
    always_ff @(posedge i_clk) begin
        if (i_start && !active) begin
            field_buf <= '0;   // Zero padding above the field
            case (i_sel)
                DUMP_REGS: begin
                    field_buf <= i_snapshot.regs;
                    last_idx  <= 7'(REGS_BYTES - 1);
                end
                DUMP_IF_ID: begin
                    field_buf[IF_ID_W-1:0] <= i_snapshot.if_id;
                    last_idx               <= 7'(IF_ID_BYTES - 1);
                end
                DUMP_ID_EX: begin
                    field_buf[ID_EX_W-1:0] <= i_snapshot.id_ex;
                    last_idx               <= 7'(ID_EX_BYTES - 1);
                end
                DUMP_EX_MEM: begin
                    field_buf[EX_MEM_W-1:0] <= i_snapshot.ex_mem;
                    last_idx                <= 7'(EX_MEM_BYTES - 1);
                end
                DUMP_MEM_WB: begin
                    field_buf[MEM_WB_W-1:0] <= i_snapshot.mem_wb;
                    last_idx                <= 7'(MEM_WB_BYTES - 1);
                end
                default: begin
                    field_buf[DATA_W-1:0] <= i_snapshot.dmem_word;
                    last_idx              <= 7'(WORD_BYTES - 1);
                end
            endcase
        end
    end

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            active     <= 1'b0;
            idx        <= '0;
            o_tx_start <= 1'b0;
            o_done     <= 1'b0;
        end else begin
            o_tx_start <= 1'b0;
            o_done     <= 1'b0;
            if (i_start && !active) begin
                active     <= 1'b1;
                idx        <= '0;
                o_tx_start <= 1'b1;
            end else if (active && i_tx_done) begin
                if (idx == last_idx) begin
                    active <= 1'b0;
                    o_done <= 1'b1;
                end else begin
                    idx        <= idx + 1'b1;
                    o_tx_start <= 1'b1;   // Next byte once the line is free
                end
            end
        end
    end

    assign o_tx_data = field_buf[{idx, 3'b000} +: 8];   // LSB first

endmodule

// File: program_loader.sv
module program_loader (
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_begin,
    input  logic [7:0]             i_count,
    input  logic [7:0]             i_byte,
    input  logic                   i_byte_valid,
    output debug_pkg::imem_write_t o_write,
    output logic                   o_done
);
    import debug_pkg::*;

    logic [DATA_W-1:0]      word_buf;
    logic [DATA_W-1:0]      assembled;
    logic [IMEM_ADDR_W-1:0] next_addr;
    logic [IMEM_ADDR_W-1:0] write_addr;
    logic [DATA_W-1:0]      write_data;
    logic [1:0]             byte_cnt;
    logic [7:0]             words_left;
    logic                   write_valid;
    logic                   take;
    logic                   last_byte;

    assign take      = i_byte_valid && (words_left != 8'd0);
    assign last_byte = take && (byte_cnt == 2'(WORD_BYTES - 1));
    assign assembled = {i_byte, word_buf[DATA_W-1:8]};   // First byte ends up lowest

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            byte_cnt    <= '0;
            words_left  <= '0;
            next_addr   <= '0;
            write_valid <= 1'b0;
            o_done      <= 1'b0;
        end else begin
            write_valid <= 1'b0;
            o_done      <= 1'b0;
            if (i_begin) begin
                byte_cnt   <= '0;
                words_left <= i_count;
                next_addr  <= '0;
            end else if (take) begin
                byte_cnt <= byte_cnt + 1'b1;
                if (last_byte) begin
                    write_valid <= 1'b1;
                    next_addr   <= next_addr + 1'b1;
                    words_left  <= words_left - 1'b1;
                    o_done      <= (words_left == 8'd1);   // With the final write
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (take) begin
            word_buf <= assembled;
        end
        if (last_byte) begin
            write_addr <= next_addr;
            write_data <= assembled;
        end
    end

    assign o_write = '{valid: write_valid, addr: write_addr, data: write_data};

endmodule

// File: debug_unit.sv
module debug_unit (
    input  logic                              i_clk,
    input  logic                              i_reset,
    input  logic                              i_uart_rx,
    input  debug_pkg::dbg_snapshot_t          i_snapshot,
    output logic                              o_uart_tx,
    output debug_pkg::imem_write_t            o_imem_write,
    output logic [debug_pkg::DMEM_ADDR_W-1:0] o_dmem_addr,
    output logic                              o_run,
    output logic                              o_step,
    output logic                              o_busy
);
    import debug_pkg::*;

    logic       tick;
    logic [7:0] rx_data;
    logic       rx_valid;
    logic       tx_start, tx_done;
    logic [7:0] tx_data;
    logic       dump_start, dump_done;
    dump_sel_e  dump_sel;
    logic       load_begin, load_byte_valid, load_done;
    logic [7:0] load_count;

    baud_tick_gen u_baud (.i_clk(i_clk), .i_reset(i_reset), .o_tick(tick));

    uart_rx u_rx (
        .i_clk(i_clk), .i_reset(i_reset), .i_tick(tick), .i_rx(i_uart_rx),
        .o_data(rx_data), .o_valid(rx_valid)
    );

    uart_tx u_tx (
        .i_clk(i_clk), .i_reset(i_reset), .i_tick(tick), .i_start(tx_start),
        .i_data(tx_data), .o_tx(o_uart_tx), .o_done(tx_done)
    );

    debug_control u_ctrl (
        .i_clk(i_clk), .i_reset(i_reset), .i_rx_data(rx_data), .i_rx_valid(rx_valid),
        .i_dump_done(dump_done), .i_load_done(load_done), .o_dump_start(dump_start),
        .o_dump_sel(dump_sel), .o_load_begin(load_begin), .o_load_count(load_count),
        .o_load_byte_valid(load_byte_valid), .o_dmem_addr(o_dmem_addr),
        .o_run(o_run), .o_step(o_step), .o_busy(o_busy)
    );

    dump_serializer u_ser (
        .i_clk(i_clk), .i_reset(i_reset), .i_start(dump_start), .i_sel(dump_sel),
        .i_snapshot(i_snapshot), .i_tx_done(tx_done), .o_tx_start(tx_start),
        .o_tx_data(tx_data), .o_done(dump_done)
    );

    program_loader u_load (
        .i_clk(i_clk), .i_reset(i_reset), .i_begin(load_begin), .i_count(load_count),
        .i_byte(rx_data), .i_byte_valid(load_byte_valid), .o_write(o_imem_write),
        .o_done(load_done)
    );

endmodule

// File: tb_uart_host.sv
module tb_uart_host (
    input  logic i_clk,
    input  logic i_line,   // Unit's serial output
    output logic o_line    // Unit's serial input
);
    timeunit 1ns;
    timeprecision 1ps;
    import debug_pkg::*;

    localparam int BIT_CLKS = BAUD_DIV * OVERSAMPLE;

    logic       line_q = 1'b1;   // Idle high
    logic [7:0] rx_q[$];
    logic [7:0] shreg = '0;
    logic       active = 1'b0;
    int         clk_cnt = 0;
    int         bit_idx = 0;
    int         frame_errors = 0;

    assign o_line = line_q;

    // 8N1 frame, LSB first, each bit held for one bit time
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(negedge i_clk);
            line_q = frame[i];
            repeat (BIT_CLKS - 1) @(negedge i_clk);
        end
    endtask

    function automatic int rx_count();
        return rx_q.size();
    endfunction

    function automatic logic [7:0] rx_pop();
        return rx_q.pop_front();
    endfunction

    // Decoder samples each bit in its middle
    always @(negedge i_clk) begin
        if (!active) begin
            if (i_line == 1'b0) begin
                active  = 1'b1;
                clk_cnt = 0;
                bit_idx = 0;
            end
        end else begin
            clk_cnt++;
            if (clk_cnt == BIT_CLKS / 2 + bit_idx * BIT_CLKS) begin
                if (bit_idx == 9) begin
                    assert (i_line == 1'b1) else begin
                        $display("Framing error: stop bit on the unit's output is low");
                        frame_errors++;
                    end
                    rx_q.push_back(shreg);
                    active = 1'b0;
                end else if (bit_idx > 0) begin
                    shreg = {i_line, shreg[7:1]};
                end
                bit_idx++;
            end
        end
    end

endmodule

// File: tb_debug_unit.sv
module tb_debug_unit;
    timeunit 1ns;
    timeprecision 1ps;
    import debug_pkg::*;

    localparam int BIT_CLKS = BAUD_DIV * OVERSAMPLE;
    localparam int BYTE_CLKS = 11 * BIT_CLKS;   // Frame plus some slack

    logic                   clk = 1'b0;
    logic                   reset = 1'b1;
    logic                   uart_rx;
    logic                   uart_tx;
    dbg_snapshot_t          snapshot;
    imem_write_t            imem_write;
    logic [DMEM_ADDR_W-1:0] dmem_addr;
    logic                   run, step, busy;

    int         errors = 0;
    int         timeouts = 0;
    int         step_count = 0;
    int         write_count = 0;
    logic [7:0] exp_addr_q[$];
    logic [31:0] exp_data_q[$];

    always #4 clk = ~clk;

    debug_unit UUT (
        .i_clk(clk), .i_reset(reset), .i_uart_rx(uart_rx), .i_snapshot(snapshot),
        .o_uart_tx(uart_tx), .o_imem_write(imem_write), .o_dmem_addr(dmem_addr),
        .o_run(run), .o_step(step), .o_busy(busy)
    );

    tb_uart_host host (.i_clk(clk), .i_line(uart_tx), .o_line(uart_rx));

    a_step_single: assert property (@(posedge clk) disable iff (reset) step |=> !step)
        else begin
            $display("FAIL o_step expected %h got %h", 1'b0, 1'b1);
            errors++;
        end
    a_step_after_byte: assert property (@(posedge clk) disable iff (reset)
        $rose(step) |-> $past(UUT.rx_valid) && !run)
        else begin
            $display("FAIL o_step expected %h got %h", 1'b0, 1'b1);
            errors++;
        end
    a_stopped_on_write: assert property (@(posedge clk) disable iff (reset)
        imem_write.valid |-> !run)
        else begin
            $display("FAIL o_run expected %h got %h", 1'b0, 1'b1);
            errors++;
        end

    always @(negedge clk) begin
        if (!reset && step) begin
            step_count++;
        end
    end

    // Writes must arrive in order with the assembled words
    always @(negedge clk) begin
        if (!reset && imem_write.valid) begin
            write_count++;
            if (exp_addr_q.size() == 0) begin
                $display("Unexpected instruction memory write");
                errors++;
            end else begin
                check_value("o_imem_write.addr", 32'(exp_addr_q.pop_front()),
                            32'(imem_write.addr));
                check_value("o_imem_write.data", exp_data_q.pop_front(), imem_write.data);
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act == exp) else begin
            $display("FAIL %s expected %h got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic fill_snapshot();
        logic [1535:0] rand_bits;
        for (int i = 0; i < 48; i++) begin
            rand_bits[i*32 +: 32] = $urandom;
        end
        snapshot = rand_bits[$bits(dbg_snapshot_t)-1:0];
    endtask

    task automatic wait_idle(input int limit);
        int cycles;
        cycles = 0;
        while (busy && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (busy) begin
            $display("Timeout: unit still busy after %0d cycles", limit);
            timeouts++;
        end
    endtask

    task automatic wait_bytes(input int n, input int limit);
        int cycles;
        cycles = 0;
        while (host.rx_count() < n && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (host.rx_count() < n) begin
            $display("Timeout: got %0d of %0d dump bytes", host.rx_count(), n);
            timeouts++;
        end
    endtask

    // Field is zero padded, bytes come LSB first
    task automatic check_dump(input logic [DUMP_BUF_W-1:0] field, input int nbytes);
        logic [7:0] got;
        check_value("o_busy", 32'd1, 32'(busy));   // Dump still on the line
        wait_bytes(nbytes, nbytes * BYTE_CLKS + 2000);
        for (int i = 0; i < nbytes && host.rx_count() > 0; i++) begin
            got = host.rx_pop();
            check_value("o_uart_tx", 32'(field[i*8 +: 8]), 32'(got));
        end
        wait_idle(2 * BYTE_CLKS);
        check_value("o_uart_tx extra bytes", 32'd0, 32'(host.rx_count()));
    endtask

    task automatic load_program(input int n);
        logic [31:0] word;
        logic        run_before;
        int          writes_before;
        run_before    = run;
        writes_before = write_count;
        host.send_byte(CMD_LOAD);
        host.send_byte(8'(n));
        check_value("o_run", 32'd0, 32'(run));
        check_value("o_busy", 32'd1, 32'(busy));
        for (int w = 0; w < n; w++) begin
            word = $urandom;
            exp_addr_q.push_back(8'(w));
            exp_data_q.push_back(word);
            for (int k = 0; k < 4; k++) begin
                host.send_byte(word[k*8 +: 8]);
            end
        end
        wait_idle(BYTE_CLKS);
        check_value("write count", 32'(writes_before + n), 32'(write_count));
        check_value("o_run", 32'(run_before), 32'(run));
    endtask

    initial begin
        logic [7:0] addr;
        int         steps_before;
        int         writes_before;
        void'($urandom(32'h418f_6396));
        fill_snapshot();
        repeat (16) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        check_value("o_run", 32'd1, 32'(run));
        check_value("o_step", 32'd0, 32'(step));
        check_value("o_imem_write.valid", 32'd0, 32'(imem_write.valid));
        check_value("o_uart_tx", 32'd1, 32'(uart_tx));
        check_value("o_busy", 32'd0, 32'(busy));

        // Register file and the four latches
        host.send_byte(CMD_REGS);
        check_dump(DUMP_BUF_W'(snapshot.regs), 128);
        host.send_byte(CMD_IF_ID);
        check_dump(DUMP_BUF_W'(snapshot.if_id), 4);
        host.send_byte(CMD_ID_EX);
        check_dump(DUMP_BUF_W'(snapshot.id_ex), 17);
        host.send_byte(CMD_EX_MEM);
        check_dump(DUMP_BUF_W'(snapshot.ex_mem), 10);
        host.send_byte(CMD_MEM_WB);
        check_dump(DUMP_BUF_W'(snapshot.mem_wb), 9);

        addr = 8'($urandom) & 8'h3f;
        host.send_byte(CMD_MEMREAD);
        host.send_byte(addr);
        check_value("o_dmem_addr", 32'(addr), 32'(dmem_addr));
        check_dump(DUMP_BUF_W'(snapshot.dmem_word), 4);

        load_program(5);

        host.send_byte(CMD_STEPMODE);
        check_value("o_run", 32'd0, 32'(run));
        for (int i = 0; i < 3; i++) begin
            steps_before = step_count;
            host.send_byte(CMD_STEP);
            check_value("o_step count", 32'(steps_before + 1), 32'(step_count));
        end
        load_program(2);   // Step mode must survive the load
        host.send_byte(CMD_CONT);
        check_value("o_run", 32'd1, 32'(run));
        steps_before = step_count;
        host.send_byte(CMD_STEP);
        check_value("o_step count", 32'(steps_before), 32'(step_count));

        // Unknown byte leaves everything as it was
        steps_before  = step_count;
        writes_before = write_count;
        host.send_byte(8'h3f);
        check_value("o_busy", 32'd0, 32'(busy));
        check_value("o_run", 32'd1, 32'(run));
        check_value("o_step count", 32'(steps_before), 32'(step_count));
        check_value("write count", 32'(writes_before), 32'(write_count));
        check_value("o_dmem_addr", 32'(addr), 32'(dmem_addr));
        check_value("o_uart_tx bytes", 32'd0, 32'(host.rx_count()));
        host.send_byte(CMD_REGS);
        check_dump(DUMP_BUF_W'(snapshot.regs), 128);

        $display("Errors: %0d checks, %0d timeouts, %0d framing", errors, timeouts,
                 host.frame_errors);
        if (errors == 0 && timeouts == 0 && host.frame_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: build.f
debug_pkg.sv
baud_tick_gen.sv
uart_rx.sv
uart_tx.sv
debug_control.sv
dump_serializer.sv
program_loader.sv
debug_unit.sv
tb_uart_host.sv
tb_debug_unit.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --assert -j 0
TOP       = tb_debug_unit
FILELIST  = build.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^Test OK$$"

clean:
	rm -rf $(OBJ_DIR)
